// File: hw/mem_pkg.sv
package mem_pkg;

    // Queue geometry
    localparam int LSQ_DEPTH = 4;  // One slot stays empty, so three entries fit
    localparam int LSQ_PTR_W = 2;
    localparam int MEM_WORDS = 256;

    // Reorder-buffer tag, zero means no pending producer
    typedef logic [3:0] rob_tag_t;

    typedef logic [31:0] word_t;

    // Word address into the data memory
    typedef logic [7:0] addr_t;

    typedef logic [LSQ_PTR_W-1:0] ptr_t;

    // Head controller states
    typedef enum logic [1:0] {
        HEAD_IDLE,
        HEAD_LOAD_READ,   // Memory read in flight
        HEAD_LOAD_SEND    // Result offered to the CDB controller
    } head_state_t;

endpackage

// File: hw/lsq.sv
module lsq (
    input  logic              clk,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  logic              dispatch_load,
    input  mem_pkg::rob_tag_t dispatch_tag,
    input  mem_pkg::addr_t    dispatch_addr,
    input  logic              dispatch_addr_valid,
    input  mem_pkg::rob_tag_t dispatch_data_tag,
    input  mem_pkg::word_t    dispatch_data,
    input  logic              cdb_valid,
    input  mem_pkg::rob_tag_t cdb_tag,
    input  mem_pkg::word_t    cdb_data,
    input  logic              cdb_is_addr,
    input  logic              deq,
    output logic              dispatch_ready,
    output logic              head_valid,
    output logic              head_ready,
    output logic              head_load,
    output mem_pkg::rob_tag_t head_tag,
    output mem_pkg::addr_t    head_addr,
    output mem_pkg::word_t    head_data
);

    mem_pkg::ptr_t wptr, rptr;
    mem_pkg::ptr_t wptr_next, rptr_next;
    logic          full, empty;
    logic          enq;

    // Per-slot fields
    logic [mem_pkg::LSQ_DEPTH-1:0] slot_valid;
    logic                          slot_load      [mem_pkg::LSQ_DEPTH];
    mem_pkg::rob_tag_t             slot_tag       [mem_pkg::LSQ_DEPTH];
    mem_pkg::addr_t                slot_addr      [mem_pkg::LSQ_DEPTH];
    logic                          slot_addr_valid[mem_pkg::LSQ_DEPTH];
    mem_pkg::rob_tag_t             slot_data_tag  [mem_pkg::LSQ_DEPTH];
    mem_pkg::word_t                slot_data      [mem_pkg::LSQ_DEPTH];

    // Incoming entry after merging a same-cycle broadcast
    mem_pkg::addr_t    in_addr;
    logic              in_addr_valid;
    mem_pkg::rob_tag_t in_data_tag;
    mem_pkg::word_t    in_data;
    logic              in_addr_hit, in_data_hit;

    assign wptr_next = wptr + mem_pkg::ptr_t'(1);
    assign rptr_next = rptr + mem_pkg::ptr_t'(1);

    assign full           = (wptr_next == rptr);
    assign empty          = (wptr == rptr);
    assign dispatch_ready = !full;
    assign enq            = dispatch_valid && !full;

    assign in_addr_hit = cdb_valid && cdb_is_addr && !dispatch_addr_valid
                         && (cdb_tag == dispatch_tag);
    assign in_data_hit = cdb_valid && !cdb_is_addr && !dispatch_load
                         && (dispatch_data_tag != '0) && (cdb_tag == dispatch_data_tag);

    assign in_addr       = in_addr_hit ? mem_pkg::addr_t'(cdb_data) : dispatch_addr;
    assign in_addr_valid = dispatch_addr_valid || in_addr_hit;
    assign in_data       = in_data_hit ? cdb_data : dispatch_data;
    // Loads never wait on data
    assign in_data_tag   = (dispatch_load || in_data_hit) ? '0 : dispatch_data_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            wptr       <= '0;
            rptr       <= '0;
            slot_valid <= '0;
        end else begin
            if (enq) begin
                wptr             <= wptr_next;
                slot_valid[wptr] <= 1'b1;
            end
            if (deq && !empty) begin
                rptr             <= rptr_next;
                slot_valid[rptr] <= 1'b0;
            end
        end
    end

    // Slot payload: enqueue write or CDB capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < mem_pkg::LSQ_DEPTH; i++) begin
            if (enq && (wptr == mem_pkg::ptr_t'(i))) begin
                slot_load[i]       <= dispatch_load;
                slot_tag[i]        <= dispatch_tag;
                slot_addr[i]       <= in_addr;
                slot_addr_valid[i] <= in_addr_valid;
                slot_data_tag[i]   <= in_data_tag;
                slot_data[i]       <= in_data;
            end else if (slot_valid[i] && cdb_valid) begin
                if (cdb_is_addr && !slot_addr_valid[i] && (slot_tag[i] == cdb_tag)) begin
                    slot_addr[i]       <= mem_pkg::addr_t'(cdb_data);
                    slot_addr_valid[i] <= 1'b1;
                end
                if (!cdb_is_addr && (slot_data_tag[i] != '0)
                        && (slot_data_tag[i] == cdb_tag)) begin
                    slot_data[i]     <= cdb_data;
                    slot_data_tag[i] <= '0;  // Store data now present
                end
            end
        end
    end

    assign head_valid = !empty;
    assign head_ready = slot_valid[rptr] && slot_addr_valid[rptr] && (slot_data_tag[rptr] == '0);
    assign head_load  = slot_load[rptr];
    assign head_tag   = slot_tag[rptr];
    assign head_addr  = slot_addr[rptr];
    assign head_data  = slot_data[rptr];

    // Head control must only pop a real entry
    a_no_deq_empty: assert property (@(posedge clk) disable iff (reset) deq |-> !empty);

    // The full rule keeps the write pointer off live entries
    a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        enq |-> !slot_valid[wptr]);

endmodule

// File: hw/lsq_head_ctrl.sv
module lsq_head_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              head_valid,
    input  logic              head_ready,
    input  logic              head_load,
    input  mem_pkg::rob_tag_t head_tag,
    input  mem_pkg::addr_t    head_addr,
    input  mem_pkg::word_t    head_data,
    input  logic              commit_valid,
    input  mem_pkg::rob_tag_t commit_tag,
    input  mem_pkg::word_t    mem_rdata,
    input  logic              load_ready,
    output logic              deq,
    output logic              commit_ready,
    output logic              mem_we,
    output logic              mem_re,
    output mem_pkg::addr_t    mem_addr,
    output mem_pkg::word_t    mem_wdata,
    output logic              load_valid,
    output mem_pkg::rob_tag_t load_tag,
    output mem_pkg::word_t    load_data
);

    mem_pkg::head_state_t state, state_next;
    logic                 head_go;
    logic                 store_go, load_go;

    assign head_go  = (state == mem_pkg::HEAD_IDLE) && head_valid && head_ready;
    // Store only writes once the ROB commits this exact entry
    assign store_go = head_go && !head_load && commit_valid && (commit_tag == head_tag);
    assign load_go  = head_go && head_load;

    assign commit_ready = store_go;
    assign mem_we       = store_go;
    assign mem_re       = load_go;
    assign deq          = store_go || load_go;
    assign mem_addr     = head_addr;
    assign mem_wdata    = head_data;
    assign load_valid   = (state == mem_pkg::HEAD_LOAD_SEND);

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::HEAD_IDLE:      if (load_go) state_next = mem_pkg::HEAD_LOAD_READ;
            mem_pkg::HEAD_LOAD_READ: state_next = mem_pkg::HEAD_LOAD_SEND;
            mem_pkg::HEAD_LOAD_SEND: if (load_ready) state_next = mem_pkg::HEAD_IDLE;
            default:                 state_next = mem_pkg::HEAD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mem_pkg::HEAD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Result registers hold through back-pressure
    always_ff @(posedge clk) begin
        if (load_go) begin
            load_tag <= head_tag;  // Head moves on after the pop
        end
        if (state == mem_pkg::HEAD_LOAD_READ) begin
            load_data <= mem_rdata;
        end
    end

    a_load_stable: assert property (@(posedge clk) disable iff (reset)
        load_valid && !load_ready |=> load_valid && $stable(load_tag) && $stable(load_data));

endmodule

// File: hw/data_mem.sv
module data_mem (
    input  logic           clk,
    input  logic           mem_we,
    input  logic           mem_re,
    input  mem_pkg::addr_t mem_addr,
    input  mem_pkg::word_t mem_wdata,
    output mem_pkg::word_t mem_rdata
);

    mem_pkg::word_t mem_array [mem_pkg::MEM_WORDS];

    // Cleared contents stand in for a preloaded image
    initial begin
        for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
            mem_array[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (mem_we) begin
            mem_array[mem_addr] <= mem_wdata;
        end
    end

    // Registered read, data one cycle after mem_re
    always_ff @(posedge clk) begin
        if (mem_re) begin
            mem_rdata <= mem_array[mem_addr];
        end
    end

endmodule

// File: hw/mem_unit.sv
module mem_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  logic              dispatch_load,
    input  mem_pkg::rob_tag_t dispatch_tag,
    input  mem_pkg::addr_t    dispatch_addr,
    input  logic              dispatch_addr_valid,
    input  mem_pkg::rob_tag_t dispatch_data_tag,
    input  mem_pkg::word_t    dispatch_data,
    output logic              dispatch_ready,
    input  logic              cdb_valid,
    input  mem_pkg::rob_tag_t cdb_tag,
    input  mem_pkg::word_t    cdb_data,
    input  logic              cdb_is_addr,
    input  logic              commit_valid,
    input  mem_pkg::rob_tag_t commit_tag,
    output logic              commit_ready,
    output logic              load_valid,
    output mem_pkg::rob_tag_t load_tag,
    output mem_pkg::word_t    load_data,
    input  logic              load_ready
);

    // Queue head to controller
    logic              head_valid, head_ready, head_load;
    mem_pkg::rob_tag_t head_tag;
    mem_pkg::addr_t    head_addr;
    mem_pkg::word_t    head_data;
    logic              deq;

    // Controller to memory
    logic              mem_we, mem_re;
    mem_pkg::addr_t    mem_addr;
    mem_pkg::word_t    mem_wdata, mem_rdata;

    lsq u_lsq (
        .clk                 (clk),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_load       (dispatch_load),
        .dispatch_tag        (dispatch_tag),
        .dispatch_addr       (dispatch_addr),
        .dispatch_addr_valid (dispatch_addr_valid),
        .dispatch_data_tag   (dispatch_data_tag),
        .dispatch_data       (dispatch_data),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_data            (cdb_data),
        .cdb_is_addr         (cdb_is_addr),
        .deq                 (deq),
        .dispatch_ready      (dispatch_ready),
        .head_valid          (head_valid),
        .head_ready          (head_ready),
        .head_load           (head_load),
        .head_tag            (head_tag),
        .head_addr           (head_addr),
        .head_data           (head_data)
    );

    lsq_head_ctrl u_head_ctrl (
        .clk          (clk),
        .reset        (reset),
        .head_valid   (head_valid),
        .head_ready   (head_ready),
        .head_load    (head_load),
        .head_tag     (head_tag),
        .head_addr    (head_addr),
        .head_data    (head_data),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .mem_rdata    (mem_rdata),
        .load_ready   (load_ready),
        .deq          (deq),
        .commit_ready (commit_ready),
        .mem_we       (mem_we),
        .mem_re       (mem_re),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .load_valid   (load_valid),
        .load_tag     (load_tag),
        .load_data    (load_data)
    );

    data_mem u_data_mem (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: sim/mem_unit_tb.sv
module mem_unit_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RAND_OPS   = 200;
    localparam int TOTAL_OPS  = 14 + RAND_OPS;
    localparam int OP_CYCLES  = 30;  // Worst case per operation, stalls included
    localparam int LIMIT_TIME = (TOTAL_OPS * OP_CYCLES + 200) * CLK_PERIOD;

    logic              clk, reset;
    logic              dispatch_valid, dispatch_load, dispatch_addr_valid, dispatch_ready;
    mem_pkg::rob_tag_t dispatch_tag, dispatch_data_tag, cdb_tag, commit_tag, load_tag;
    mem_pkg::addr_t    dispatch_addr;
    mem_pkg::word_t    dispatch_data, cdb_data, load_data;
    logic              cdb_valid, cdb_is_addr, commit_valid, commit_ready;
    logic              load_valid, load_ready;

    // Operations in program order
    logic              op_load  [TOTAL_OPS];
    mem_pkg::rob_tag_t op_tag   [TOTAL_OPS];
    mem_pkg::addr_t    op_addr  [TOTAL_OPS];
    mem_pkg::word_t    op_data  [TOTAL_OPS];
    int                op_delay [TOTAL_OPS];
    int                op_due   [TOTAL_OPS];  // Cycle from which broadcasts may go out
    logic              addr_pend[TOTAL_OPS];
    logic              data_pend[TOTAL_OPS];

    int                n_ops, disp_idx, disp_limit, oldest, cyc, errors, loads_seen;
    logic              hold_commit, hold_load, bad_commit, was_stalled;
    mem_pkg::rob_tag_t held_tag;
    mem_pkg::word_t    held_data;
    logic [15:0]       lfsr_state;

    mem_unit uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // Memory word seen by operation idx once every older store is applied
    function automatic mem_pkg::word_t expected_word(input int idx);
        mem_pkg::word_t img [mem_pkg::MEM_WORDS];
        for (int a = 0; a < mem_pkg::MEM_WORDS; a++) begin
            img[a] = '0;
        end
        for (int j = 0; j < idx; j++) begin
            if (!op_load[j]) begin
                img[op_addr[j]] = op_data[j];
            end
        end
        return img[op_addr[idx]];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, actual, expected);
        end
    endtask

    task automatic add_op(input logic load, input mem_pkg::addr_t addr, input mem_pkg::word_t data,
                          input logic addr_late, input logic data_late, input int delay);
        op_load[n_ops]   = load;
        op_tag[n_ops]    = mem_pkg::rob_tag_t'((n_ops % 15) + 1);  // Tags 1 to 15
        op_addr[n_ops]   = addr;
        op_data[n_ops]   = data;
        op_delay[n_ops]  = delay;
        addr_pend[n_ops] = addr_late;
        data_pend[n_ops] = !load && data_late;
        n_ops++;
    endtask

    // Dispatch, CDB, ROB commit and load_ready, all on the falling edge
    always @(negedge clk) begin
        int bi;
        cyc++;
        dispatch_valid = 1'b0;
        if (disp_idx < disp_limit) begin
            dispatch_valid      = 1'b1;
            dispatch_load       = op_load[disp_idx];
            dispatch_tag        = op_tag[disp_idx];
            dispatch_addr       = addr_pend[disp_idx] ? '0 : op_addr[disp_idx];
            dispatch_addr_valid = !addr_pend[disp_idx];
            dispatch_data_tag   = data_pend[disp_idx] ? op_tag[disp_idx] : '0;
            dispatch_data       = data_pend[disp_idx] ? '0 : op_data[disp_idx];
            if (dispatch_ready) begin  // Accepted on the coming edge
                op_due[disp_idx] = cyc + op_delay[disp_idx];
                disp_idx++;
            end
        end
        cdb_valid = 1'b0;
        bi = oldest;
        while (bi < disp_idx && !cdb_valid) begin
            if ((addr_pend[bi] || data_pend[bi]) && op_due[bi] <= cyc) begin
                cdb_valid   = 1'b1;
                cdb_tag     = op_tag[bi];
                cdb_is_addr = addr_pend[bi];
                if (addr_pend[bi]) begin
                    cdb_data      = 32'(op_addr[bi]);
                    addr_pend[bi] = 1'b0;
                end else begin
                    cdb_data      = op_data[bi];
                    data_pend[bi] = 1'b0;
                end
            end
            bi++;
        end
        commit_valid = 1'b0;
        if (!hold_commit && oldest < disp_idx && !op_load[oldest]) begin
            commit_valid = 1'b1;
            commit_tag   = bad_commit ? mem_pkg::rob_tag_t'((op_tag[oldest] % 15) + 1)
                                      : op_tag[oldest];
        end
        load_ready = !hold_load && (rand_bits(2) != 32'd0);  // Stall one cycle in four
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (bad_commit) begin
                check_value("commit_ready", 32'(commit_ready), 32'd0);
            end
            if (was_stalled) begin  // Result must hold under back-pressure
                check_value("load_valid", 32'(load_valid), 32'd1);
                check_value("load_tag", 32'(load_tag), 32'(held_tag));
                check_value("load_data", load_data, held_data);
            end
            was_stalled = load_valid && !load_ready;
            held_tag    = load_tag;
            held_data   = load_data;
            if (commit_ready) begin
                check_value("commit_valid", 32'(commit_valid), 32'd1);
                check_value("commit_tag", 32'(commit_tag), 32'(op_tag[oldest]));
                oldest++;
            end
            if (load_valid && load_ready) begin
                check_value("load_tag", 32'(load_tag), 32'(op_tag[oldest]));
                check_value("load_data", load_data, expected_word(oldest));
                loads_seen++;
                oldest++;
            end
        end
    end

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_load = 1'b0;
        dispatch_tag = '0;
        dispatch_addr = '0;
        dispatch_addr_valid = 1'b0;
        dispatch_data_tag = '0;
        dispatch_data = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_data = '0;
        cdb_is_addr = 1'b0;
        commit_valid = 1'b0;
        commit_tag = '0;
        load_ready = 1'b0;
        {n_ops, disp_idx, disp_limit, oldest, cyc, errors, loads_seen} = '0;
        {hold_commit, hold_load, bad_commit, was_stalled} = '0;
        lfsr_state = 16'd73;
        add_op(1'b0, 8'h15, 32'hCAFE_0001, 1'b0, 1'b0, 0);
        add_op(1'b1, 8'h15, '0, 1'b0, 1'b0, 0);
        add_op(1'b1, 8'h3C, '0, 1'b0, 1'b0, 0);  // Never written
        add_op(1'b0, 8'h55, 32'h1234_5678, 1'b0, 1'b1, 0);  // Data merged at dispatch
        add_op(1'b1, 8'h55, '0, 1'b1, 1'b0, 0);
        add_op(1'b0, 8'h95, 32'h0BAD_F00D, 1'b1, 1'b1, 2);
        add_op(1'b1, 8'h95, '0, 1'b0, 1'b0, 0);
        add_op(1'b0, 8'hD5, 32'h5A5A_A5A5, 1'b0, 1'b0, 0);
        add_op(1'b1, 8'hD5, '0, 1'b0, 1'b0, 0);
        add_op(1'b1, 8'h55, '0, 1'b0, 1'b0, 0);
        for (int k = 0; k < 4; k++) begin
            add_op(1'b0, mem_pkg::addr_t'({k[1:0], 6'h15}), 32'h7000_0000 + k, 1'b0, 1'b0, 0);
        end
        for (int k = 0; k < RAND_OPS; k++) begin
            r = rand_bits(7);
            add_op(r[6], mem_pkg::addr_t'({r[5:4], 6'h15}), rand_bits(32), r[3], r[2],
                   int'(r[1:0]));
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        #1;
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);
        check_value("load_valid", 32'(load_valid), 32'd0);
        check_value("commit_ready", 32'(commit_ready), 32'd0);
        disp_limit = 7;
        wait (oldest == 7);
        // Store at the head sees only wrong commit tags
        bad_commit = 1'b1;
        disp_limit = 9;
        repeat (12) @(posedge clk);
        #1;
        check_value("mem_array", uut.u_data_mem.mem_array[8'hD5], expected_word(7));
        check_value("load_valid", 32'(load_valid), 32'd0);
        bad_commit = 1'b0;
        wait (oldest == 9);
        hold_commit = 1'b1;
        hold_load = 1'b1;
        disp_limit = 14;
        repeat (20) @(posedge clk);
        #1;
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd0);
        check_value("dispatch count", disp_idx, 13);  // Load in flight plus three stores
        check_value("load_valid", 32'(load_valid), 32'd1);
        hold_commit = 1'b0;
        hold_load = 1'b0;
        wait (oldest == 14);
        disp_limit = n_ops;
        wait (oldest == n_ops);
        $display("Run complete: %0d operations, %0d loads checked, %0d errors",
                 n_ops, loads_seen, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(LIMIT_TIME);
        $display("Timeout: only %0d of %0d operations finished by time %0t, %0d errors",
                 oldest, TOTAL_OPS, $time, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: mem_unit.f
hw/mem_pkg.sv
hw/lsq.sv
hw/lsq_head_ctrl.sv
hw/data_mem.sv
hw/mem_unit.sv
sim/mem_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory unit testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --top-module mem_unit_tb -f mem_unit.f -o mem_unit_sim \
    && ./obj_dir/mem_unit_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"

grep -q "ERRORS FOUND" "$LOG" \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
